// File: sim.f
hdl/mem_pkg.sv
hdl/core_pkg.sv
hdl/mem_arb.sv
hdl/ram_model.sv
hdl/fetch_unit.sv
hdl/insn_decode.sv
hdl/exec_unit.sv
hdl/core_top.sv
bench/core_sva.sv
bench/core_tb.sv

// File: run.sh
#!/bin/sh
# build and run the core testbench with Verilator, from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module core_tb -f sim.f -o core_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/core_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "tests failed" sim.log; then
  exit 1
fi
exit 0

// File: prog.hex
// one 32-bit word per line, @ gives the word index
// instruction: [31:28] opcode, [27:0] operand
20000011
20000abc
2fffffff
20000000
10000040
20000005
10000041
10000042
10000100
70000123
00000000
20000077
10000043
20000078
10000040
9abcdef0
20000079
@40
deadbeef
12345678
cafef00d
0badc0de
@fe
200000fe
10000041

// File: bench/core_tb.sv
`timescale 1ns/1ps

module core_tb import mem_pkg::*, core_pkg::*; ();

  localparam int max_wait = 200; // cycles allowed between two results

  logic              clk = 1'b0;
  logic              rstn;
  logic              run;
  logic [word_w-1:0] start_pc;
  logic              result_valid;
  logic              result_ready;
  result_t           result;

  logic [data_w-1:0] image [ram_words]; // same image as the RAM
  integer            seed = 32'h291b58b1;
  int                mismatches = 0;
  int                timeouts = 0;
  int                assert_fails;

  always #50 clk = ~clk;

  core_top u_core_top (
    .clk, .rstn, .run, .start_pc,
    .result_valid, .result_ready, .result
  );

  // expected result for the instruction at pc
  function automatic result_t predict(input logic [word_w-1:0] pc);
    result_t              exp;
    logic [word_w-1:0]    word;
    logic [operand_w-1:0] operand;
    exp.pc    = pc;
    exp.value = '0;
    exp.err   = 1'b0;
    if (pc >= ram_words * 4) begin
      exp.op  = op_illegal; // fetch beyond the RAM
      exp.err = 1'b1;
    end else begin
      word    = image[pc[ram_idx_w+1:2]];
      operand = word[operand_w-1:0];
      case (word[word_w-1:word_w-4])
        4'd2: begin
          exp.op    = op_imm;
          exp.value = {4'h0, operand};
        end
        4'd1: begin
          exp.op = op_load;
          if (operand < ram_words) exp.value = image[operand[ram_idx_w-1:0]];
          else exp.err = 1'b1;
        end
        default: exp.op = op_illegal;
      endcase
    end
    return exp;
  endfunction

  task automatic check_result(input string name, input result_t exp, input result_t act);
    if (act !== exp) begin
      mismatches++;
      $display(
        "MISMATCH %s expected pc=%h op=%h value=%h err=%b actual pc=%h op=%h value=%h err=%b",
        name, exp.pc, exp.op, exp.value, exp.err,
        act.pc, act.op, act.value, act.err);
    end
  endtask

  task automatic expect_no_result(input string name, input logic act);
    if (act !== 1'b0) begin
      mismatches++;
      $display("MISMATCH %s expected result_valid=0 actual result_valid=%b", name, act);
    end
  endtask

  // four reset cycles with result_valid checked low
  task automatic apply_reset(input string name, input logic [word_w-1:0] pc_start);
    @(posedge clk);
    rstn         <= 1'b0;
    run          <= 1'b0;
    result_ready <= 1'b0;
    start_pc     <= pc_start;
    repeat (3) begin
      @(posedge clk);
      @(negedge clk);
      expect_no_result(name, result_valid);
    end
    @(posedge clk);
    rstn <= 1'b1;
  endtask

  task automatic run_program(input string name, input logic [word_w-1:0] pc_start,
                             input int count, input bit random_ready);
    logic [word_w-1:0] pc;
    logic [31:0]       r;
    int                got;
    int                waited;
    apply_reset(name, pc_start);
    @(posedge clk);
    run          <= 1'b1;
    result_ready <= !random_ready;
    pc     = pc_start;
    got    = 0;
    waited = 0;
    while (got < count && waited < max_wait) begin
      @(negedge clk);
      if (result_valid && result_ready) begin // transfers on the next edge
        check_result(name, predict(pc), result);
        pc     = pc + 32'd4;
        got    = got + 1;
        waited = 0;
      end else begin
        waited = waited + 1;
      end
      @(posedge clk);
      if (random_ready) begin
        r = $random(seed);
        result_ready <= r[0];
      end
    end
    if (got < count) begin
      timeouts++;
      $display("timeout in %s: only %0d of %0d results arrived", name, got, count);
    end
    run          <= 1'b0;
    result_ready <= 1'b0;
  endtask

  task automatic test_reset();
    apply_reset("test_reset", 32'h0);
    repeat (8) begin
      @(negedge clk);
      expect_no_result("test_reset", result_valid); // run still low
    end
  endtask

  task automatic test_imm();
    run_program("test_imm", 32'h00, 4, 1'b0);
  endtask

  task automatic test_load();
    run_program("test_load", 32'h10, 4, 1'b0);
  endtask

  task automatic test_errors();
    run_program("test_errors", 32'h20, 3, 1'b0);
    run_program("test_errors", 32'h3f8, 4, 1'b0); // last two words then two past the end
  endtask

  task automatic test_backpressure();
    run_program("test_backpressure", 32'h2c, 6, 1'b1);
  endtask

  initial begin
    rstn         = 1'b0;
    run          = 1'b0;
    start_pc     = '0;
    result_ready = 1'b0;
    $readmemh("prog.hex", image);

    test_reset();
    test_imm();
    test_load();
    test_errors();
    test_backpressure();

    assert_fails = u_core_top.u_core_sva.fail_count;
    $display("errors: %0d mismatches, %0d timeouts, %0d assertion failures",
             mismatches, timeouts, assert_fails);
    if (mismatches == 0 && timeouts == 0 && assert_fails == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: bench/core_sva.sv
`timescale 1ns/1ps

module core_sva import mem_pkg::*, core_pkg::*; (
  input logic     clk,
  input logic     rstn,
  input logic     ifu_arvalid,
  input logic     ifu_arready,
  input ar_chan_t ifu_ar,
  input logic     lsu_arvalid,
  input logic     lsu_arready,
  input ar_chan_t lsu_ar,
  input logic     ram_arvalid,
  input logic     ram_arready,
  input ar_chan_t ram_ar,
  input logic     ram_rvalid,
  input logic     ram_rready,
  input logic     ifu_rvalid,
  input logic     ifu_rready,
  input r_chan_t  ifu_r,
  input logic     lsu_rvalid,
  input logic     lsu_rready,
  input r_chan_t  lsu_r,
  input logic     result_valid,
  input logic     result_ready,
  input result_t  result
);
  logic in_flight; // ram address accepted and data not yet taken
  int   fail_count = 0;

  always_ff @(posedge clk) begin
    if (!rstn) in_flight <= 1'b0;
    else if (ram_arvalid && ram_arready) in_flight <= 1'b1;
    else if (ram_rvalid && ram_rready) in_flight <= 1'b0;
  end

  ifu_ar_stable: assert property (@(posedge clk) disable iff (!rstn)
    ifu_arvalid && !ifu_arready |=> ifu_arvalid && $stable(ifu_ar))
    else begin
      fail_count++;
      $error("fetch address dropped or changed before transfer");
    end

  lsu_ar_stable: assert property (@(posedge clk) disable iff (!rstn)
    lsu_arvalid && !lsu_arready |=> lsu_arvalid && $stable(lsu_ar))
    else begin
      fail_count++;
      $error("load address dropped or changed before transfer");
    end

  ram_ar_stable: assert property (@(posedge clk) disable iff (!rstn)
    ram_arvalid && !ram_arready |=> ram_arvalid && $stable(ram_ar))
    else begin
      fail_count++;
      $error("ram address dropped or changed before transfer");
    end

  ifu_r_stable: assert property (@(posedge clk) disable iff (!rstn)
    ifu_rvalid && !ifu_rready |=> ifu_rvalid && $stable(ifu_r))
    else begin
      fail_count++;
      $error("fetch response dropped or changed before transfer");
    end

  lsu_r_stable: assert property (@(posedge clk) disable iff (!rstn)
    lsu_rvalid && !lsu_rready |=> lsu_rvalid && $stable(lsu_r))
    else begin
      fail_count++;
      $error("load response dropped or changed before transfer");
    end

  result_stable: assert property (@(posedge clk) disable iff (!rstn)
    result_valid && !result_ready |=> result_valid && $stable(result))
    else begin
      fail_count++;
      $error("result dropped or changed before transfer");
    end

  one_in_flight: assert property (@(posedge clk) disable iff (!rstn)
    in_flight |-> !ram_arvalid)
    else begin
      fail_count++;
      $error("second ram address while a read is in flight");
    end

  quiet_after_reset: assert property (@(posedge clk)
    $rose(rstn) |-> !(ifu_arvalid || lsu_arvalid || ram_arvalid || ram_rvalid ||
                      ifu_rvalid || lsu_rvalid || result_valid || ram_rready ||
                      ifu_arready || lsu_arready))
    else begin
      fail_count++;
      $error("valid or ready high in the first cycle after reset");
    end

endmodule

bind core_top core_sva u_core_sva (
  .clk, .rstn,
  .ifu_arvalid, .ifu_arready, .ifu_ar,
  .lsu_arvalid, .lsu_arready, .lsu_ar,
  .ram_arvalid, .ram_arready, .ram_ar, .ram_rvalid, .ram_rready,
  .ifu_rvalid, .ifu_rready, .ifu_r,
  .lsu_rvalid, .lsu_rready, .lsu_r,
  .result_valid, .result_ready, .result
);

// File: hdl/core_top.sv
`timescale 1ns/1ps

module core_top import mem_pkg::*, core_pkg::*; (
  input  logic              clk,
  input  logic              rstn,
  input  logic              run,
  input  logic [word_w-1:0] start_pc,
  output logic              result_valid,
  input  logic              result_ready,
  output result_t           result
);
  logic              ifu_arvalid, ifu_arready, ifu_rvalid, ifu_rready;
  logic              lsu_arvalid, lsu_arready, lsu_rvalid, lsu_rready;
  logic              ram_arvalid, ram_arready, ram_rvalid, ram_rready;
  ar_chan_t          ifu_ar, lsu_ar, ram_ar;
  r_chan_t           ifu_r, lsu_r, ram_r;
  logic              fetch_valid, fetch_ready, fetch_err;
  logic [word_w-1:0] fetch_word, fetch_pc;
  logic              dec_valid, dec_ready, dec_err;
  decoded_t          dec;

  fetch_unit u_fetch_unit (
    .clk, .rstn, .run, .start_pc,
    .ifu_arvalid, .ifu_arready, .ifu_ar,
    .ifu_rvalid, .ifu_rready, .ifu_r,
    .fetch_valid, .fetch_ready, .fetch_word, .fetch_pc, .fetch_err
  );

  insn_decode u_insn_decode (
    .clk, .rstn,
    .fetch_valid, .fetch_ready, .fetch_word, .fetch_pc, .fetch_err,
    .dec_valid, .dec_ready, .dec, .dec_err
  );

  exec_unit u_exec_unit (
    .clk, .rstn,
    .dec_valid, .dec_ready, .dec, .dec_err,
    .lsu_arvalid, .lsu_arready, .lsu_ar,
    .lsu_rvalid, .lsu_rready, .lsu_r,
    .result_valid, .result_ready, .result
  );

  mem_arb u_mem_arb (
    .clk, .rstn,
    .ifu_arvalid, .ifu_arready, .ifu_ar, .ifu_rvalid, .ifu_rready, .ifu_r,
    .lsu_arvalid, .lsu_arready, .lsu_ar, .lsu_rvalid, .lsu_rready, .lsu_r,
    .ram_arvalid, .ram_arready, .ram_ar, .ram_rvalid, .ram_rready, .ram_r
  );

  ram_model u_ram_model (
    .clk, .rstn,
    .arvalid (ram_arvalid),
    .arready (ram_arready),
    .ar      (ram_ar),
    .rvalid  (ram_rvalid),
    .rready  (ram_rready),
    .r       (ram_r)
  );

endmodule

// File: hdl/exec_unit.sv
`timescale 1ns/1ps

module exec_unit import mem_pkg::*, core_pkg::*; (
  input  logic     clk,
  input  logic     rstn,
  input  logic     dec_valid,
  output logic     dec_ready,
  input  decoded_t dec,
  input  logic     dec_err,
  output logic     lsu_arvalid,
  input  logic     lsu_arready,
  output ar_chan_t lsu_ar,
  input  logic     lsu_rvalid,
  output logic     lsu_rready,
  input  r_chan_t  lsu_r,
  output logic     result_valid,
  input  logic     result_ready,
  output result_t  result
);
  typedef enum logic [1:0] {
    st_idle,
    st_load_req,
    st_load_wait,
    st_output
  } exec_state_e;

  exec_state_e state;

  assign dec_ready    = (state == st_idle);
  assign lsu_arvalid  = (state == st_load_req);
  assign lsu_rready   = (state == st_load_wait);
  assign result_valid = (state == st_output);

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle:      if (dec_valid) state <= (dec.op == op_load) ? st_load_req : st_output;
        st_load_req:  if (lsu_arready) state <= st_load_wait;
        st_load_wait: if (lsu_rvalid) state <= st_output;
        st_output:    if (result_ready) state <= st_idle;
        default:      state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (dec_valid && dec_ready) begin
      result.pc    <= dec.pc;
      result.op    <= dec.op;
      result.value <= (dec.op == op_imm) ? word_w'(dec.operand) : '0;
      result.err   <= (dec.op == op_illegal) && dec_err;
      lsu_ar       <= '{araddr: addr_w'({dec.operand, 2'b00})}; // word index to byte address
    end else if (lsu_rvalid && lsu_rready) begin
      result.value <= (lsu_r.rresp == resp_okay) ? lsu_r.rdata : '0;
      result.err   <= (lsu_r.rresp != resp_okay);
    end
  end

endmodule

// File: hdl/insn_decode.sv
`timescale 1ns/1ps

module insn_decode import core_pkg::*; (
  input  logic              clk,
  input  logic              rstn,
  input  logic              fetch_valid,
  output logic              fetch_ready,
  input  logic [word_w-1:0] fetch_word,
  input  logic [word_w-1:0] fetch_pc,
  input  logic              fetch_err,
  output logic              dec_valid,
  input  logic              dec_ready,
  output decoded_t          dec,
  output logic              dec_err
);
  opcode_e dec_op;

  assign fetch_ready = ~dec_valid | dec_ready;

  always_comb begin
    case (fetch_word[word_w-1 -: op_w])
      op_imm:  dec_op = op_imm;
      op_load: dec_op = op_load;
      default: dec_op = op_illegal; // anything unknown
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstn) dec_valid <= 1'b0;
    else if (fetch_valid && fetch_ready) dec_valid <= 1'b1;
    else if (dec_ready) dec_valid <= 1'b0;
  end

  always_ff @(posedge clk) begin
    if (fetch_valid && fetch_ready) begin
      dec     <= '{pc: fetch_pc, op: dec_op, operand: fetch_word[operand_w-1:0]};
      dec_err <= fetch_err;
    end
  end

endmodule

// File: hdl/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit import mem_pkg::*, core_pkg::*; (
  input  logic              clk,
  input  logic              rstn,
  input  logic              run,
  input  logic [word_w-1:0] start_pc,
  output logic              ifu_arvalid,
  input  logic              ifu_arready,
  output ar_chan_t          ifu_ar,
  input  logic              ifu_rvalid,
  output logic              ifu_rready,
  input  r_chan_t           ifu_r,
  output logic              fetch_valid,
  input  logic              fetch_ready,
  output logic [word_w-1:0] fetch_word,
  output logic [word_w-1:0] fetch_pc,
  output logic              fetch_err
);
  typedef enum logic [1:0] {
    st_idle,
    st_request,
    st_wait_data,
    st_hand_off
  } fetch_state_e;

  fetch_state_e      state;
  logic [word_w-1:0] pc;

  assign ifu_arvalid = (state == st_request);
  assign ifu_ar      = '{araddr: pc};
  assign ifu_rready  = (state == st_wait_data);
  assign fetch_valid = (state == st_hand_off);

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state <= st_idle;
      pc    <= start_pc;
    end else begin
      case (state)
        st_idle:      if (run) state <= st_request;
        st_request:   if (ifu_arready) state <= st_wait_data;
        st_wait_data: if (ifu_rvalid) begin
          state <= st_hand_off;
          pc    <= pc + 32'd4;
        end
        st_hand_off:  if (fetch_ready) state <= run ? st_request : st_idle;
        default:      state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (ifu_rvalid && ifu_rready) begin
      fetch_pc   <= pc;
      fetch_err  <= (ifu_r.rresp != resp_okay);
      fetch_word <= (ifu_r.rresp == resp_okay) ? ifu_r.rdata : illegal_insn;
    end
  end

endmodule

// File: hdl/ram_model.sv
`timescale 1ns/1ps

module ram_model import mem_pkg::*; (
  input  logic     clk,
  input  logic     rstn,
  input  logic     arvalid,
  output logic     arready,
  input  ar_chan_t ar,
  output logic     rvalid,
  input  logic     rready,
  output r_chan_t  r
);
  logic [data_w-1:0]    mem [ram_words];
  logic [addr_w-1:0]    addr_q;
  logic [lat_cnt_w-1:0] count;
  logic                 pending;
  logic                 in_range;

  initial $readmemh("prog.hex", mem);

  assign in_range = (addr_q[addr_w-1:ram_idx_w+2] == '0);

  always_ff @(posedge clk) begin
    if (!rstn) begin
      arready <= 1'b0;
      rvalid  <= 1'b0;
      pending <= 1'b0;
      count   <= '0;
    end else if (arvalid && arready) begin
      arready <= 1'b0;
      pending <= 1'b1;
      count   <= lat_cnt_w'(ram_latency - 1);
    end else if (pending) begin
      if (count == '0) begin
        pending <= 1'b0;
        rvalid  <= 1'b1;
      end else begin
        count <= count - 1'b1;
      end
    end else if (rvalid && rready) begin
      rvalid  <= 1'b0;
      arready <= 1'b1;
    end else if (!rvalid) begin
      arready <= 1'b1; // idle again
    end
  end

  always_ff @(posedge clk) begin
    if (arvalid && arready) addr_q <= ar.araddr;
    if (pending && count == '0) begin
      if (in_range) r <= '{rdata: mem[addr_q[ram_idx_w+1:2]], rresp: resp_okay};
      else r <= '{rdata: '0, rresp: resp_slverr};
    end
  end

endmodule

// File: hdl/mem_arb.sv
`timescale 1ns/1ps

module mem_arb import mem_pkg::*; (
  input  logic     clk,
  input  logic     rstn,
  input  logic     ifu_arvalid,
  output logic     ifu_arready,
  input  ar_chan_t ifu_ar,
  output logic     ifu_rvalid,
  input  logic     ifu_rready,
  output r_chan_t  ifu_r,
  input  logic     lsu_arvalid,
  output logic     lsu_arready,
  input  ar_chan_t lsu_ar,
  output logic     lsu_rvalid,
  input  logic     lsu_rready,
  output r_chan_t  lsu_r,
  output logic     ram_arvalid,
  input  logic     ram_arready,
  output ar_chan_t ram_ar,
  input  logic     ram_rvalid,
  output logic     ram_rready,
  input  r_chan_t  ram_r
);
  // index 0 is fetch, index 1 is load
  logic [1:0] arvalid, arready, rvalid, rready, hold_valid, out_free;
  ar_chan_t   ar [2];
  ar_chan_t   hold_ar [2];
  r_chan_t    r_out [2];
  r_chan_t    park_r;
  logic       park_valid, park_src;
  logic       busy, last_src, tag;
  logic       grant, grant_src;

  assign arvalid     = {lsu_arvalid, ifu_arvalid};
  assign rready      = {lsu_rready, ifu_rready};
  assign ar[0]       = ifu_ar;
  assign ar[1]       = lsu_ar;
  assign ifu_arready = arready[0];
  assign lsu_arready = arready[1];
  assign ifu_rvalid  = rvalid[0];
  assign lsu_rvalid  = rvalid[1];
  assign ifu_r       = r_out[0];
  assign lsu_r       = r_out[1];

  assign out_free  = ~rvalid | rready;
  assign grant     = ~busy & (|hold_valid);
  assign grant_src = (&hold_valid) ? ~last_src : hold_valid[1]; // alternate on contention

  always_ff @(posedge clk) begin
    if (!rstn) begin
      hold_valid  <= '0;
      arready     <= '0;
      rvalid      <= '0;
      busy        <= 1'b0;
      last_src    <= 1'b1; // fetch wins the first tie
      ram_arvalid <= 1'b0;
      ram_rready  <= 1'b0;
      park_valid  <= 1'b0;
    end else begin
      for (int m = 0; m < 2; m++) begin
        if (arvalid[m] && arready[m]) begin
          hold_valid[m] <= 1'b1;
          arready[m]    <= 1'b0;
        end else if (grant && grant_src == 1'(m)) begin
          hold_valid[m] <= 1'b0;
          arready[m]    <= 1'b1;
        end else begin
          arready[m] <= ~hold_valid[m];
        end
        if (rvalid[m] && rready[m]) rvalid[m] <= 1'b0;
      end

      if (grant) begin
        busy        <= 1'b1;
        ram_arvalid <= 1'b1;
        last_src    <= grant_src;
      end
      if (ram_arvalid && ram_arready) ram_arvalid <= 1'b0;

      if (ram_rvalid && ram_rready) begin
        busy <= 1'b0; // delivered or parked, next address may go
        if (out_free[tag]) begin
          rvalid[tag] <= 1'b1;
        end else begin
          park_valid <= 1'b1;
          ram_rready <= 1'b0;
        end
      end else if (park_valid && out_free[park_src]) begin
        park_valid       <= 1'b0;
        ram_rready       <= 1'b1;
        rvalid[park_src] <= 1'b1;
      end else if (!park_valid) begin
        ram_rready <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int m = 0; m < 2; m++) begin
      if (arvalid[m] && arready[m]) hold_ar[m] <= ar[m];
    end
    if (grant) ram_ar <= hold_ar[grant_src];
    if (ram_arvalid && ram_arready) tag <= last_src;
    if (ram_rvalid && ram_rready) begin
      if (out_free[tag]) begin
        r_out[tag] <= ram_r;
      end else begin
        park_r   <= ram_r;
        park_src <= tag;
      end
    end else if (park_valid && out_free[park_src]) begin
      r_out[park_src] <= park_r;
    end
  end

endmodule

// File: hdl/core_pkg.sv
package core_pkg;

  localparam int word_w    = 32;
  localparam int op_w      = 4;
  localparam int operand_w = 28;

  typedef enum logic [op_w-1:0] {
    op_load    = 4'd1,
    op_imm     = 4'd2,
    op_illegal = 4'hf
  } opcode_e;

  // substituted for a word whose fetch failed
  localparam logic [word_w-1:0] illegal_insn = {op_illegal, {operand_w{1'b0}}};

  typedef struct packed {
    logic [word_w-1:0]    pc;
    opcode_e              op;
    logic [operand_w-1:0] operand;
  } decoded_t;

  typedef struct packed {
    logic [word_w-1:0] pc;
    opcode_e           op;
    logic [word_w-1:0] value;
    logic              err;
  } result_t;

endpackage

// File: hdl/mem_pkg.sv
package mem_pkg;

  localparam int addr_w      = 32;
  localparam int data_w      = 32;
  localparam int ram_words   = 256;
  localparam int ram_latency = 2;
  localparam int ram_idx_w   = $clog2(ram_words);
  localparam int lat_cnt_w   = $clog2(ram_latency + 1);

  // axi style encodings, exokay and decerr unused
  typedef enum logic [1:0] {
    resp_okay   = 2'b00,
    resp_slverr = 2'b10
  } resp_e;

  typedef struct packed {
    logic [addr_w-1:0] araddr;
  } ar_chan_t;

  typedef struct packed {
    logic [data_w-1:0] rdata;
    resp_e             rresp;
  } r_chan_t;

endpackage
